//--- decode.sv
`default_nettype none
`timescale 1ns/100ps
`include "proc_defs.svh"

module decode import proc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    instr,
    input  word_t    pc_plus1,
    input  logic     valid,
    input  logic     redirect,
    input  logic     wb_en,        // Register file write port
    input  reg_idx_t wb_reg,
    input  word_t    wb_data,
    output logic     err,          // Sticky illegal opcode
    output logic     halt_seen,
    id_ex_if.dec     id_ex
);

    word_t    regs [`PROC_NREGS];  // Register file
    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm;
    alu_op_t  alu_op;
    wb_sel_t  wb_sel;
    logic     reg_we;
    logic     mem_we;
    logic     is_branch;
    logic     is_jump;
    logic     is_halt;
    logic     illegal;
    logic     i_form;              // ADDI/LD/ST/BEQZ layout
    logic     live;
    logic     halt_q;

    assign op   = opcode_t'(instr[15:12]);
    assign live = valid && !redirect;               // Not being flushed this cycle
    assign rs   = instr[8:6];
    assign rt   = i_form ? instr[11:9] : instr[5:3];   // ST data sits in the rd field

    //////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////
    always_comb begin
        alu_op    = ALU_ADD;
        wb_sel    = WB_ALU;
        rd        = instr[11:9];
        reg_we    = 1'b0;
        mem_we    = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_halt   = 1'b0;
        illegal   = 1'b0;
        i_form    = 1'b0;
        case (op)
            OP_NOP:  ;
            OP_ADD:  reg_we = 1'b1;
            OP_SUB:  begin
                reg_we = 1'b1;
                alu_op = ALU_SUB;
            end
            OP_AND:  begin
                reg_we = 1'b1;
                alu_op = ALU_AND;
            end
            OP_XOR:  begin
                reg_we = 1'b1;
                alu_op = ALU_XOR;
            end
            OP_ADDI: begin
                reg_we = 1'b1;
                i_form = 1'b1;
            end
            OP_LD:   begin
                reg_we = 1'b1;
                i_form = 1'b1;
                wb_sel = WB_MEM;
            end
            OP_ST:   begin
                mem_we = 1'b1;
                i_form = 1'b1;
            end
            OP_BEQZ: begin
                is_branch = 1'b1;
                i_form    = 1'b1;
            end
            OP_J:    is_jump = 1'b1;
            OP_JAL:  begin
                is_jump = 1'b1;
                reg_we  = 1'b1;
                wb_sel  = WB_LINK;
                rd      = reg_idx_t'(`PROC_NREGS - 1);   // Link register r7
            end
            OP_HALT: is_halt = 1'b1;
            default: illegal = 1'b1;
        endcase
    end

    // 12-bit jump offset, else 6-bit immediate
    assign imm = is_jump ? {{(`PROC_WIDTH-12){instr[11]}}, instr[11:0]}
                         : {{(`PROC_WIDTH-6){instr[5]}}, instr[5:0]};

    // Read with write-through from the writeback port
    assign rs_val = (wb_en && wb_reg == rs) ? wb_data : regs[rs];
    assign rt_val = (wb_en && wb_reg == rt) ? wb_data : regs[rt];

    always_ff @(posedge clk) begin
        if (wb_en) regs[wb_reg] <= wb_data;
    end

    // Sticky flags
    always_ff @(posedge clk) begin
        if (rst) begin
            err    <= 1'b0;
            halt_q <= 1'b0;
        end else begin
            if (live && illegal) err <= 1'b1;
            if (live && is_halt) halt_q <= 1'b1;
        end
    end

    assign halt_seen = halt_q || (live && is_halt);   // Same cycle as HALT in decode

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) id_ex.valid <= 1'b0;
        else     id_ex.valid <= live;
    end

    always_ff @(posedge clk) begin
        id_ex.op        <= op;
        id_ex.alu_op    <= alu_op;
        id_ex.rd        <= rd;
        id_ex.rs_val    <= rs_val;
        id_ex.rt_val    <= rt_val;
        id_ex.imm       <= imm;
        id_ex.pc_plus1  <= pc_plus1;
        id_ex.wb_sel    <= wb_sel;
        id_ex.reg_we    <= reg_we;
        id_ex.mem_we    <= mem_we;
        id_ex.is_branch <= is_branch;
        id_ex.is_jump   <= is_jump;
    end

endmodule

`default_nettype wire

//--- ex_mem_if.sv
`default_nettype none
`timescale 1ns/100ps

// Execute result bundle, execute -> memory_wb
interface ex_mem_if import proc_pkg::*; ();

    logic     valid;
    word_t    result;       // ALU out or memory address
    word_t    store_data;
    reg_idx_t rd;
    wb_sel_t  wb_sel;
    logic     reg_we;
    logic     mem_we;
    word_t    pc_plus1;     // Link value for JAL
    logic     halt;         // HALT riding to the end of the pipe

    modport exe (
        output valid, result, store_data, rd, wb_sel, reg_we, mem_we, pc_plus1, halt
    );

    modport mem (
        input valid, result, store_data, rd, wb_sel, reg_we, mem_we, pc_plus1, halt
    );

endinterface

`default_nettype wire

//--- execute.sv
`default_nettype none
`timescale 1ns/100ps

module execute import proc_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    id_ex_if.exe  id_ex,
    ex_mem_if.exe ex_mem,
    output logic  redirect,    // One cycle per taken branch/jump
    output pc_t   target
);

    word_t op_b;
    word_t alu_out;
    logic  use_imm;

    // Immediate replaces rt for ADDI and address calc
    assign use_imm = id_ex.op inside {OP_ADDI, OP_LD, OP_ST};
    assign op_b    = use_imm ? id_ex.imm : id_ex.rt_val;

    // ALU
    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_out = id_ex.rs_val - op_b;
            ALU_AND: alu_out = id_ex.rs_val & op_b;
            ALU_XOR: alu_out = id_ex.rs_val ^ op_b;
            default: alu_out = id_ex.rs_val + op_b;   // ADD, ADDI, LD/ST address
        endcase
    end

    //////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////
    assign redirect = id_ex.valid &&
                      (id_ex.is_jump || (id_ex.is_branch && id_ex.rs_val == '0));
    assign target   = id_ex.pc_plus1 + id_ex.imm;     // Relative to PC + 1

    //////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) ex_mem.valid <= 1'b0;
        else     ex_mem.valid <= id_ex.valid;
    end

    always_ff @(posedge clk) begin
        ex_mem.result     <= alu_out;
        ex_mem.store_data <= id_ex.rt_val;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.wb_sel     <= id_ex.wb_sel;
        ex_mem.reg_we     <= id_ex.reg_we;
        ex_mem.mem_we     <= id_ex.mem_we;
        ex_mem.pc_plus1   <= id_ex.pc_plus1;   // JAL link value
        ex_mem.halt       <= (id_ex.op == OP_HALT);
    end

endmodule

`default_nettype wire

//--- fetch.sv
`default_nettype none
`timescale 1ns/100ps
`include "proc_defs.svh"

module fetch import proc_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  redirect,     // Taken branch/jump from execute
    input  pc_t   target,
    input  logic  halt_seen,    // Level, freezes PC
    output pc_t   pc,           // To instruction port
    input  word_t instr_in,     // Returned combinationally for pc
    output word_t instr,
    output word_t pc_plus1,
    output logic  valid
);

    pc_t pc_seq;

    assign pc_seq = pc + 1'b1;

    // Program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `PROC_RESET_PC;
        end else if (redirect) begin
            pc <= target;           // Redirect wins over halt
        end else if (!halt_seen) begin
            pc <= pc_seq;
        end
    end

    //////////////////////////////////////////////////
    // IF/ID register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= !redirect && !halt_seen;   // Flushed or halted slot
        end
    end

    always_ff @(posedge clk) begin
        instr    <= instr_in;
        pc_plus1 <= pc_seq;
    end

endmodule

`default_nettype wire

//--- id_ex_if.sv
`default_nettype none
`timescale 1ns/100ps

// Decoded instruction bundle, decode -> execute
interface id_ex_if import proc_pkg::*; ();

    logic     valid;
    opcode_t  op;
    alu_op_t  alu_op;
    reg_idx_t rd;
    word_t    rs_val;
    word_t    rt_val;       // Also store data
    word_t    imm;          // Already sign extended
    word_t    pc_plus1;
    wb_sel_t  wb_sel;
    logic     reg_we;
    logic     mem_we;
    logic     is_branch;
    logic     is_jump;

    modport dec (
        output valid, op, alu_op, rd, rs_val, rt_val, imm, pc_plus1,
        output wb_sel, reg_we, mem_we, is_branch, is_jump
    );

    modport exe (
        input valid, op, alu_op, rd, rs_val, rt_val, imm, pc_plus1,
        input wb_sel, reg_we, mem_we, is_branch, is_jump
    );

endinterface

`default_nettype wire

//--- memory_wb.sv
`default_nettype none
`timescale 1ns/100ps
`include "proc_defs.svh"

module memory_wb import proc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    ex_mem_if.mem    ex_mem,
    output logic     wb_en,      // Register file write strobe
    output reg_idx_t wb_reg,
    output word_t    wb_data,
    output logic     halted      // Sticky
);

    localparam int DMEM_AW = $clog2(`PROC_DMEM_DEPTH);

    word_t              dmem [`PROC_DMEM_DEPTH];
    logic [DMEM_AW-1:0] addr;
    word_t              rd_data;
    word_t              wb_value;

    assign addr = ex_mem.result[DMEM_AW-1:0];   // Upper address bits dropped

    // Data memory, async read
    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.mem_we) dmem[addr] <= ex_mem.store_data;
    end

    assign rd_data = dmem[addr];

    always_comb begin
        case (ex_mem.wb_sel)
            WB_MEM:  wb_value = rd_data;
            WB_LINK: wb_value = ex_mem.pc_plus1;
            default: wb_value = ex_mem.result;
        endcase
    end

    //////////////////////////////////////////////////
    // MEM/WB register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb_en <= ex_mem.valid && ex_mem.reg_we;
            if (ex_mem.valid && ex_mem.halt) halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= ex_mem.rd;
        wb_data <= wb_value;
    end

endmodule

`default_nettype wire

//--- proc.sv
`default_nettype none
`timescale 1ns/100ps

module proc import proc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    instr,     // Instruction port, word for pc
    output pc_t      pc,
    output logic     wb_en,     // Writeback observation
    output reg_idx_t wb_reg,
    output word_t    wb_data,
    output logic     halted,
    output logic     err
);

    word_t if_instr;
    word_t if_pc_plus1;
    logic  if_valid;
    logic  redirect;
    pc_t   target;
    logic  halt_seen;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    //////////////////////////////////////////////////
    // Fetch -> decode -> execute -> memory/writeback
    //////////////////////////////////////////////////
    fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .target    (target),
        .halt_seen (halt_seen),
        .pc        (pc),
        .instr_in  (instr),
        .instr     (if_instr),
        .pc_plus1  (if_pc_plus1),
        .valid     (if_valid)
    );

    decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .instr     (if_instr),
        .pc_plus1  (if_pc_plus1),
        .valid     (if_valid),
        .redirect  (redirect),
        .wb_en     (wb_en),       // Same strobe seen at the top
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .err       (err),
        .halt_seen (halt_seen),
        .id_ex     (id_ex)
    );

    execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .redirect  (redirect),
        .target    (target)
    );

    memory_wb u_memory_wb (
        .clk       (clk),
        .rst       (rst),
        .ex_mem    (ex_mem),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .halted    (halted)
    );

endmodule

`default_nettype wire

//--- proc_defs.svh
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Datapath and instruction width
`define PROC_WIDTH 16

// Architectural registers r0..r7
`define PROC_NREGS 8

// Data memory words, byte address not used
`define PROC_DMEM_DEPTH 256

// First fetch address out of reset
`define PROC_RESET_PC 16'h0000

`endif

//--- proc_golden.txt
// Program words at @00 and @40, one instruction word per line
// Expected at @80 and @c0: program length, writeback count, err, then reg data pairs
@00
a000  // 00 JAL +0, r7 = 1
21f8  // 01 SUB r0,r7,r7
0000  // 02 NOP
0000  // 03 NOP
5205  // 04 ADDI r1,r0,5
543d  // 05 ADDI r2,r0,-3
560c  // 06 ADDI r3,r0,12
0000  // 07 NOP
1850  // 08 ADD r4,r1,r2
2a58  // 09 SUB r5,r1,r3
3c98  // 0a AND r6,r2,r3
4298  // 0b XOR r1,r2,r3
7ac4  // 0c ST r5,[r3+4]
0000  // 0d NOP
64c4  // 0e LD r2,[r3+4]
0000 0000  // 0f 10 NOP
8085  // 11 BEQZ r2,+5 not taken
8002  // 12 BEQZ r0,+2 taken
5c01 5a01  // 13 14 flushed
9003  // 15 J +3
5c01 5a01  // 16 17 flushed
5801  // 18 jumped over
a002  // 19 JAL +2, r7 = 26
5c01 5a01  // 1a 1b flushed
57c1  // 1c ADDI r3,r7,1
b000  // 1d HALT
5201  // 1e never executes
@40
a000  // 00 JAL +0
21f8  // 01 SUB r0,r7,r7
0000 0000  // 02 03 NOP
523f  // 04 ADDI r1,r0,-1
0000 0000  // 05 06 NOP
1448  // 07 ADD r2,r1,r1
f000  // 08 illegal opcode
b000  // 09 HALT
0000  // 0a NOP
@80
001f 000c 0000
7 0001
0 0000
1 0005
2 fffd
3 000c
4 0002
5 fff9
6 000c
1 fff1
2 fff9
7 001a
3 001b
@c0
000b 0004 0001
7 0001
0 0000
1 ffff
2 fffe

//--- proc_pkg.sv
`default_nettype none
`include "proc_defs.svh"

package proc_pkg;

    typedef logic [`PROC_WIDTH-1:0] word_t;             // Data or instruction word
    typedef logic [`PROC_WIDTH-1:0] pc_t;               // Instruction word address
    typedef logic [$clog2(`PROC_NREGS)-1:0] reg_idx_t;  // Register number

    // Opcodes in bits 15..12, 4'hc..4'hf are illegal
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LD   = 4'h6,
        OP_ST   = 4'h7,
        OP_BEQZ = 4'h8,
        OP_J    = 4'h9,
        OP_JAL  = 4'ha,
        OP_HALT = 4'hb
    } opcode_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} alu_op_t;

    // Writeback source
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_t;

endpackage

`default_nettype wire

//--- sources.f
+incdir+.
proc_pkg.sv
id_ex_if.sv
ex_mem_if.sv
fetch.sv
decode.sv
execute.sv
memory_wb.sv
proc.sv
tb_proc.sv

//--- tb_proc.sv
`default_nettype none
`timescale 1ns/100ps

module tb_proc import proc_pkg::*; ();

    //////////////////////////////////////////////////
    // Golden image layout, word offsets
    //////////////////////////////////////////////////
    localparam int    PROG1_BASE = 'h00;   // Main program
    localparam int    PROG2_BASE = 'h40;   // Rerun section with illegal opcode
    localparam int    EXP1_BASE  = 'h80;   // Length, count, err, then reg/data pairs
    localparam int    EXP2_BASE  = 'hc0;
    localparam word_t NOP_WORD   = {OP_NOP, 12'h000};

    logic     clk;
    logic     rst;
    word_t    instr;
    pc_t      pc;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     halted;
    logic     err;

    word_t image [256];         // Whole golden file
    word_t prog [64];           // ROM of the current run
    int    prog_len  = 0;
    int    exp_base  = 0;
    int    exp_count = 0;
    int    wb_idx    = 0;       // Writebacks seen this run
    int    cycles    = 0;
    int    limit     = 0;
    logic  checking  = 1'b0;

    proc u_proc (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data),
        .halted  (halted),
        .err     (err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Instruction ROM, NOP past the end or for an unknown pc
    always_comb begin
        if (pc < prog_len) instr = prog[pc[5:0]];
        else               instr = NOP_WORD;
    end

    task automatic abort_sim();
        $display("TEST FAIL");
        $fatal(1, "Stopped at first failure");
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_wb(input reg_idx_t got_reg, input word_t got_data,
                            input reg_idx_t exp_reg, input word_t exp_data);
        if (got_reg !== exp_reg || got_data !== exp_data) begin
            $display("Error at %0t ns: writeback %0d is r%0d=%h, expected r%0d=%h",
                     $time, wb_idx, got_reg, got_data, exp_reg, exp_data);
            abort_sim();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abort_sim();
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0t ns: %0d writebacks, expected %0d", $time, got, exp);
            abort_sim();
        end
    endtask

    // Writeback monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (checking && !rst) begin
            cycles = cycles + 1;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles: halted never rose", limit);
                abort_sim();
            end else if (wb_en) begin
                if (halted) begin
                    $display("Error at %0t ns: writeback to r%0d after halted", $time, wb_reg);
                    abort_sim();
                end else if (wb_idx >= exp_count) begin
                    $display("Error at %0t ns: extra writeback r%0d=%h", $time, wb_reg, wb_data);
                    abort_sim();
                end else begin
                    check_wb(wb_reg, wb_data, reg_idx_t'(image[exp_base + 3 + 2 * wb_idx]),
                             image[exp_base + 4 + 2 * wb_idx]);
                    wb_idx = wb_idx + 1;
                end
            end
        end
    end

    // Load one program, reset, run to HALT and check the totals
    task automatic run_program(input int prog_base, input int base);
        int len;
        len = image[base];
        checking = 1'b0;
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < 64; i++) begin
            prog[i] = (i < len) ? image[prog_base + i] : NOP_WORD;
        end
        prog_len  = len;
        exp_base  = base;
        exp_count = image[base + 1];
        limit     = 4 * len + 50;     // Generous bound on pipeline run time
        cycles    = 0;
        wb_idx    = 0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        checking = 1'b1;
        wait (halted === 1'b1);
        repeat (8) @(posedge clk);    // Drain window, no writeback expected
        #1 checking = 1'b0;
        check_count(wb_idx, exp_count);
        check_flag(err, image[base + 2][0], "err");
    endtask

    initial begin
        rst = 1'b1;
        $readmemh("proc_golden.txt", image);
        if ($isunknown(image[EXP1_BASE]) || $isunknown(image[EXP2_BASE])) begin
            $display("Golden file proc_golden.txt is missing or incomplete");
            abort_sim();
        end else begin
            run_program(PROG1_BASE, EXP1_BASE);   // ALU, memory, branches, HALT
            run_program(PROG2_BASE, EXP2_BASE);   // Fresh reset, illegal opcode
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
